/* verilog/cpu_bus_pkg.sv */
/*
 * CPU bus request and response structs, peripheral address union,
 * address map selects and interrupt controller register indices
 */

`default_nettype none

package cpu_bus_pkg;

    // address map selects in the top nibble of the 24-bit byte address
    localparam logic [3:0] SELECT_RAM = 4'd0;
    localparam logic [3:0] SELECT_IRQ = 4'd1;

    localparam int RAM_WORDS = 256;
    localparam int IRQ_LINES = 8;

    // interrupt controller register indices with index 3 reading zero
    localparam logic [1:0] IRQ_REG_PENDING = 2'd0;
    localparam logic [1:0] IRQ_REG_MASK    = 2'd1;
    localparam logic [1:0] IRQ_REG_LINES   = 2'd2;

    // wstrb of zero means read
    typedef struct packed {
        logic        valid;
        logic [3:0]  wstrb;
        logic [23:0] address;
        logic [31:0] write_data;
    } mem_req_t;

    typedef struct packed {
        logic        ready;
        logic [31:0] read_data;
    } mem_rsp_t;

    typedef struct packed {
        logic [3:0]  select;
        logic [9:0]  unused;
        logic [7:0]  word_index;
        logic [1:0]  byte_offset;
    } periph_ram_address_t;

    typedef struct packed {
        logic [3:0]  select;
        logic [15:0] unused;
        logic [1:0]  reg_index;
        logic [1:0]  byte_offset;
    } periph_reg_address_t;

    typedef union packed {
        periph_ram_address_t ram;
        periph_reg_address_t regs;
    } periph_address_u;

endpackage

`default_nettype wire

/* verilog/cpu_peripheral_sync.sv */
/*
 * CPU to peripheral bridge between clk_1x and clk_2x
 * requests and eoi bits go 1x register then 2x falling edge register
 * responses come back with a ready rising edge detect
 */

`timescale 1ns/1ps
`default_nettype none

module cpu_peripheral_sync (
    input  wire                    clk_1x,
    input  wire                    clk_2x,
    input  wire                    rst,

    input  wire cpu_bus_pkg::mem_req_t cpu_req,
    input  wire [31:0]             cpu_eoi,
    input  wire cpu_bus_pkg::mem_rsp_t periph_rsp,
    input  wire [31:0]             irq_pending,

    output cpu_bus_pkg::mem_req_t  periph_req,
    output logic [31:0]            periph_eoi,
    output cpu_bus_pkg::mem_rsp_t  cpu_rsp,
    output logic [31:0]            cpu_irq
);

    cpu_bus_pkg::mem_req_t req_1x;
    logic [31:0]           eoi_1x;

    cpu_bus_pkg::mem_rsp_t rsp_2x;
    logic                  ready_d;
    logic                  ready_rose;
    logic [31:0]           irq_2x;

    // 1x capture of the request and eoi bits
    always_ff @(posedge clk_1x) begin
        req_1x <= cpu_req;
        eoi_1x <= cpu_eoi;
        if (rst) begin
            req_1x.valid <= 1'b0;
            eoi_1x <= '0;
        end
    end

    // falling edge leaves half a 2x cycle before the decoder samples
    always_ff @(negedge clk_2x) begin
        periph_req <= req_1x;
        periph_eoi <= eoi_1x;
        if (rst) begin
            periph_req.valid <= 1'b0;
            periph_eoi <= '0;
        end
    end

    // ready level turned into a single pulse that spans one 1x edge
    always_ff @(negedge clk_2x) begin
        rsp_2x <= periph_rsp;
        ready_d <= rsp_2x.ready;
        ready_rose <= rsp_2x.ready && !ready_d;
        irq_2x <= irq_pending;
        if (rst) begin
            rsp_2x.ready <= 1'b0;
            ready_d <= 1'b0;
            ready_rose <= 1'b0;
            irq_2x <= '0;
        end
    end

    // read data was sampled with the ready level so it lines up with the pulse
    always_ff @(posedge clk_1x) begin
        cpu_rsp.read_data <= rsp_2x.read_data;
        cpu_rsp.ready <= ready_rose;
        cpu_irq <= irq_2x;
        if (rst) begin
            cpu_rsp.ready <= 1'b0;
            cpu_irq <= '0;
        end
    end

endmodule

`default_nettype wire

/* verilog/peripheral_bus_decoder.sv */
/*
 * 2x side bus decoder
 * issues RAM and register accesses once per request,
 * muxes read data and holds ready until valid drops
 */

`timescale 1ns/1ps
`default_nettype none

module peripheral_bus_decoder (
    input  wire                        clk_2x,
    input  wire                        rst,
    input  wire cpu_bus_pkg::mem_req_t periph_req,
    input  wire [31:0]                 ram_read_data,
    input  wire [31:0]                 irq_read_data,

    output cpu_bus_pkg::mem_rsp_t       periph_rsp,
    output logic                        ram_read_en,
    output logic [3:0]                  ram_write,
    output logic                        irq_reg_write,
    output cpu_bus_pkg::periph_address_u access_address,
    output logic [31:0]                 access_write_data
);

    logic        started;
    logic        issue;
    logic        is_write;
    logic        ram_selected;
    logic        irq_selected;
    logic        complete;
    logic [31:0] read_data_mux;

    assign access_address = periph_req.address;
    assign access_write_data = periph_req.write_data;

    assign ram_selected = access_address.ram.select == cpu_bus_pkg::SELECT_RAM;
    assign irq_selected = access_address.ram.select == cpu_bus_pkg::SELECT_IRQ;
    assign is_write = |periph_req.wstrb;

    // first cycle of a request only
    assign issue = periph_req.valid && !started;

    assign ram_write = (issue && ram_selected) ? periph_req.wstrb : 4'b0000;
    assign ram_read_en = issue && ram_selected && !is_write;
    assign irq_reg_write = issue && irq_selected && is_write;

    // unmapped selects read back zero
    always_comb begin
        case (access_address.ram.select)
            cpu_bus_pkg::SELECT_RAM: read_data_mux = ram_read_data;
            cpu_bus_pkg::SELECT_IRQ: read_data_mux = irq_read_data;
            default: read_data_mux = '0;
        endcase
    end

    // RAM data is registered by now, so capture it with the ready level
    assign complete = periph_req.valid && started && !periph_rsp.ready;

    always_ff @(posedge clk_2x) begin
        if (complete) begin
            periph_rsp.read_data <= read_data_mux;
        end
        started <= periph_req.valid;
        periph_rsp.ready <= periph_req.valid && started;
        if (rst) begin
            started <= 1'b0;
            periph_rsp.ready <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* verilog/scratch_ram.sv */
/*
 * scratch RAM on the 2x side
 * byte lane write strobes, registered read on read enable
 */

`timescale 1ns/1ps
`default_nettype none

module scratch_ram (
    input  wire                              clk_2x,
    input  wire                              ram_read_en,
    input  wire [3:0]                        ram_write,
    input  wire cpu_bus_pkg::periph_address_u access_address,
    input  wire [31:0]                       access_write_data,

    output logic [31:0]                      ram_read_data
);

    logic [31:0] mem [cpu_bus_pkg::RAM_WORDS];
    logic [7:0]  word_index;

    assign word_index = access_address.ram.word_index;

    always_ff @(posedge clk_2x) begin
        for (int lane = 0; lane < 4; lane++) begin
            if (ram_write[lane]) begin
                mem[word_index][lane*8 +: 8] <= access_write_data[lane*8 +: 8];
            end
        end
    end

    // read data holds until the next read enable
    always_ff @(posedge clk_2x) begin
        if (ram_read_en) begin
            ram_read_data <= mem[word_index];
        end
    end

endmodule

`default_nettype wire

/* verilog/irq_controller.sv */
/*
 * interrupt controller
 * rising edge pending bits, mask register, eoi clearing, register reads
 */

`timescale 1ns/1ps
`default_nettype none

module irq_controller (
    input  wire                              clk_2x,
    input  wire                              rst,
    input  wire [cpu_bus_pkg::IRQ_LINES-1:0] irq_lines,
    input  wire [31:0]                       periph_eoi,
    input  wire                              irq_reg_write,
    input  wire cpu_bus_pkg::periph_address_u access_address,
    input  wire [31:0]                       access_write_data,

    output logic [31:0]                      irq_read_data,
    output logic [31:0]                      irq_pending
);

    localparam int PAD_BITS = 32 - cpu_bus_pkg::IRQ_LINES;

    logic [cpu_bus_pkg::IRQ_LINES-1:0] lines_prev;
    logic [cpu_bus_pkg::IRQ_LINES-1:0] rising;
    logic [cpu_bus_pkg::IRQ_LINES-1:0] pending;
    logic [cpu_bus_pkg::IRQ_LINES-1:0] mask;

    assign rising = irq_lines & ~lines_prev;

    always_ff @(posedge clk_2x) begin
        lines_prev <= irq_lines;
        // a new edge wins over eoi in the same cycle
        pending <= (pending & ~periph_eoi[cpu_bus_pkg::IRQ_LINES-1:0]) | rising;
        if (irq_reg_write && access_address.regs.reg_index == cpu_bus_pkg::IRQ_REG_MASK) begin
            mask <= access_write_data[cpu_bus_pkg::IRQ_LINES-1:0];
        end
        if (rst) begin
            lines_prev <= '0;
            pending <= '0;
            mask <= '0;
        end
    end

    assign irq_pending = {{PAD_BITS{1'b0}}, pending & mask};

    always_comb begin
        case (access_address.regs.reg_index)
            cpu_bus_pkg::IRQ_REG_PENDING: irq_read_data = {{PAD_BITS{1'b0}}, pending};
            cpu_bus_pkg::IRQ_REG_MASK:    irq_read_data = {{PAD_BITS{1'b0}}, mask};
            cpu_bus_pkg::IRQ_REG_LINES:   irq_read_data = {{PAD_BITS{1'b0}}, irq_lines};
            default: irq_read_data = '0;
        endcase
    end

endmodule

`default_nettype wire

/* verilog/peripheral_subsystem.sv */
/*
 * peripheral subsystem top level
 * bridge, bus decoder, scratch RAM and interrupt controller
 */

`timescale 1ns/1ps
`default_nettype none

module peripheral_subsystem (
    input  wire                              clk_1x,
    input  wire                              clk_2x,
    input  wire                              rst,
    input  wire cpu_bus_pkg::mem_req_t       cpu_req,
    input  wire [31:0]                       cpu_eoi,
    input  wire [cpu_bus_pkg::IRQ_LINES-1:0] irq_lines,

    output cpu_bus_pkg::mem_rsp_t            cpu_rsp,
    output logic [31:0]                      cpu_irq
);

    cpu_bus_pkg::mem_req_t        periph_req;
    cpu_bus_pkg::mem_rsp_t        periph_rsp;
    logic [31:0]                  periph_eoi;
    logic [31:0]                  irq_pending;

    logic                         ram_read_en;
    logic [3:0]                   ram_write;
    logic                         irq_reg_write;
    cpu_bus_pkg::periph_address_u access_address;
    logic [31:0]                  access_write_data;
    logic [31:0]                  ram_read_data;
    logic [31:0]                  irq_read_data;

    cpu_peripheral_sync cpu_peripheral_sync_inst (
        .clk_1x(clk_1x),
        .clk_2x(clk_2x),
        .rst(rst),
        .cpu_req(cpu_req),
        .cpu_eoi(cpu_eoi),
        .periph_rsp(periph_rsp),
        .irq_pending(irq_pending),
        .periph_req(periph_req),
        .periph_eoi(periph_eoi),
        .cpu_rsp(cpu_rsp),
        .cpu_irq(cpu_irq)
    );

    peripheral_bus_decoder peripheral_bus_decoder_inst (
        .clk_2x(clk_2x),
        .rst(rst),
        .periph_req(periph_req),
        .ram_read_data(ram_read_data),
        .irq_read_data(irq_read_data),
        .periph_rsp(periph_rsp),
        .ram_read_en(ram_read_en),
        .ram_write(ram_write),
        .irq_reg_write(irq_reg_write),
        .access_address(access_address),
        .access_write_data(access_write_data)
    );

    scratch_ram scratch_ram_inst (
        .clk_2x(clk_2x),
        .ram_read_en(ram_read_en),
        .ram_write(ram_write),
        .access_address(access_address),
        .access_write_data(access_write_data),
        .ram_read_data(ram_read_data)
    );

    irq_controller irq_controller_inst (
        .clk_2x(clk_2x),
        .rst(rst),
        .irq_lines(irq_lines),
        .periph_eoi(periph_eoi),
        .irq_reg_write(irq_reg_write),
        .access_address(access_address),
        .access_write_data(access_write_data),
        .irq_read_data(irq_read_data),
        .irq_pending(irq_pending)
    );

endmodule

`default_nettype wire

/* test/peripheral_subsystem_assertions.sv */
/*
 * concurrent assertions on the CPU side of the bridge
 * bound into cpu_peripheral_sync
 */

`timescale 1ns/1ps
`default_nettype none

module peripheral_subsystem_assertions (
    input wire                        clk_1x,
    input wire                        rst,
    input wire cpu_bus_pkg::mem_req_t cpu_req,
    input wire cpu_bus_pkg::mem_req_t periph_req,
    input wire cpu_bus_pkg::mem_rsp_t cpu_rsp
);

    int failures = 0;

    // one pulse per access
    ready_single_pulse: assert property (@(posedge clk_1x) disable iff (rst)
        cpu_rsp.ready |=> !cpu_rsp.ready)
        else begin
            $error("cpu_rsp.ready high for two cycles in a row");
            failures++;
        end

    ready_low_after_reset: assert property (@(posedge clk_1x) rst |=> !cpu_rsp.ready)
        else begin
            $error("cpu_rsp.ready not low after reset");
            failures++;
        end

    // one 1x register then one 2x falling edge register
    valid_follows_cpu: assert property (@(posedge clk_1x) disable iff (rst)
        periph_req.valid == $past(cpu_req.valid))
        else begin
            $error("periph_req.valid does not follow cpu_req.valid");
            failures++;
        end

endmodule

bind cpu_peripheral_sync peripheral_subsystem_assertions sync_assertions_inst (
    .clk_1x(clk_1x),
    .rst(rst),
    .cpu_req(cpu_req),
    .periph_req(periph_req),
    .cpu_rsp(cpu_rsp)
);

`default_nettype wire

/* test/peripheral_subsystem_tb.sv */
/*
 * testbench for the peripheral subsystem
 * clocks, reset, transaction table with a reference model, checks and timeout
 */

`timescale 1ns/1ps
`default_nettype none

module peripheral_subsystem_tb;

    typedef enum logic [1:0] {ACC_READ, ACC_WRITE, SET_LINES, PULSE_EOI} kind_t;

    typedef struct packed {
        kind_t       kind;
        logic [23:0] address;
        logic [3:0]  wstrb;
        logic [31:0] data;
        logic [31:0] exp_data;
        logic [31:0] exp_irq;
    } entry_t;

    localparam int RESET_CYCLES = 10;
    localparam int READY_WAIT = 20;

    logic                              clk_1x;
    logic                              clk_2x;
    logic                              rst;
    cpu_bus_pkg::mem_req_t             cpu_req;
    logic [31:0]                       cpu_eoi;
    logic [cpu_bus_pkg::IRQ_LINES-1:0] irq_lines;
    cpu_bus_pkg::mem_rsp_t             cpu_rsp;
    logic [31:0]                       cpu_irq;

    entry_t      stimulus[$];
    logic [31:0] model_ram [cpu_bus_pkg::RAM_WORDS];
    logic [31:0] lfsr_state = 32'h5275_155b;
    int          checks = 0;
    int          errors = 0;
    int          accesses = 0;
    int          ready_pulses = 0;
    int          cycles = 0;
    int          cycle_limit = 0;
    int          assert_failures;

    peripheral_subsystem peripheral_subsystem_inst (
        .clk_1x(clk_1x),
        .clk_2x(clk_2x),
        .rst(rst),
        .cpu_req(cpu_req),
        .cpu_eoi(cpu_eoi),
        .irq_lines(irq_lines),
        .cpu_rsp(cpu_rsp),
        .cpu_irq(cpu_irq)
    );

    // 2x toggles every 2 ns, 1x follows every second 2x rising edge
    initial begin
        clk_1x = 1'b0;
        clk_2x = 1'b0;
        forever begin
            #2;
            clk_2x = ~clk_2x;
            if (clk_2x) begin
                clk_1x = ~clk_1x;
            end
        end
    end

    always @(negedge clk_1x) begin
        if (cpu_rsp.ready) begin
            ready_pulses++;
        end
    end

    always @(posedge clk_1x) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("run did not finish the table within %0d cycles", cycle_limit);
            $display("Simulation failed");
            $finish;
        end
    end

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] random_word();
        logic [31:0] word;
        word = '0;
        for (int i = 0; i < 32; i++) begin
            word = {word[30:0], lfsr_state[0]};
            lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
        end
        return word;
    endfunction

    task automatic add_entry(input kind_t kind, input logic [23:0] address,
                             input logic [3:0] wstrb, input logic [31:0] data,
                             input logic [31:0] exp_data, input logic [31:0] exp_irq);
        stimulus.push_back('{kind, address, wstrb, data, exp_data, exp_irq});
    endtask

    task automatic build_table();
        // full then partial strobe writes to RAM words 1 and 255
        add_entry(ACC_WRITE, 24'h000004, 4'hF, 32'h0, 32'h0, 32'h0);
        add_entry(ACC_WRITE, 24'h0003FC, 4'hF, 32'h0, 32'h0, 32'h0);
        add_entry(ACC_WRITE, 24'h000004, 4'b0110, 32'h0, 32'h0, 32'h0);
        add_entry(ACC_WRITE, 24'h0003FC, 4'b1001, 32'h0, 32'h0, 32'h0);
        add_entry(ACC_READ, 24'h000004, 4'h0, 32'h0, 32'h0, 32'h0);
        add_entry(ACC_READ, 24'h0003FC, 4'h0, 32'h0, 32'h0, 32'h0);
        // mask DA written and read back, then index 3 which reads zero
        add_entry(ACC_WRITE, 24'h100004, 4'hF, 32'hFFFF_FFDA, 32'h0, 32'h0);
        add_entry(ACC_READ, 24'h100004, 4'h0, 32'h0, 32'h0000_00DA, 32'h0);
        add_entry(ACC_READ, 24'h10000C, 4'h0, 32'h0, 32'h0, 32'h0);
        // edges set pending and lines held high stay cleared after eoi
        add_entry(SET_LINES, 24'h0, 4'h0, 32'h0F, 32'h0, 32'h0);
        add_entry(ACC_READ, 24'h100000, 4'h0, 32'h0, 32'h0F, 32'h0A);
        add_entry(PULSE_EOI, 24'h0, 4'h0, 32'h03, 32'h0, 32'h0);
        add_entry(ACC_READ, 24'h100000, 4'h0, 32'h0, 32'h0C, 32'h08);
        add_entry(SET_LINES, 24'h0, 4'h0, 32'h8F, 32'h0, 32'h0);
        add_entry(ACC_READ, 24'h100000, 4'h0, 32'h0, 32'h8C, 32'h88);
        add_entry(PULSE_EOI, 24'h0, 4'h0, 32'hFFFF_FFFF, 32'h0, 32'h0);
        add_entry(ACC_READ, 24'h100000, 4'h0, 32'h0, 32'h0, 32'h0);
        // unmapped selects alias RAM word 1 and the mask index
        add_entry(ACC_READ, 24'h200010, 4'h0, 32'h0, 32'h0, 32'h0);
        add_entry(ACC_WRITE, 24'h200004, 4'hF, 32'hDEAD_BEEF, 32'h0, 32'h0);
        add_entry(ACC_WRITE, 24'h300004, 4'hF, 32'h0, 32'h0, 32'h0);
        add_entry(ACC_READ, 24'h000004, 4'h0, 32'h0, 32'h0, 32'h0);
        add_entry(ACC_READ, 24'h100004, 4'h0, 32'h0, 32'h0000_00DA, 32'h0);
    endtask

    task automatic do_access(input entry_t e);
        cpu_bus_pkg::periph_address_u addr;
        logic [31:0] write_data;
        logic [31:0] expected;
        int waited;
        addr = e.address;
        write_data = e.data;
        if (e.kind == ACC_WRITE && addr.ram.select == cpu_bus_pkg::SELECT_RAM) begin
            write_data = random_word();
        end
        cpu_req <= '{valid: 1'b1, wstrb: e.wstrb, address: e.address, write_data: write_data};
        accesses++;
        waited = 0;
        @(negedge clk_1x);
        while (!cpu_rsp.ready && waited < READY_WAIT) begin
            @(negedge clk_1x);
            waited++;
        end
        if (!cpu_rsp.ready) begin
            $display("no ready within %0d cycles for address %h", READY_WAIT, e.address);
            errors++;
        end else begin
            if (e.kind == ACC_READ) begin
                expected = e.exp_data;
                if (addr.ram.select == cpu_bus_pkg::SELECT_RAM) begin
                    expected = model_ram[addr.ram.word_index];
                end
                checks++;
                if (cpu_rsp.read_data !== expected) begin
                    $display("FAIL cpu_rsp.read_data at %h: got %h, expected %h",
                             e.address, cpu_rsp.read_data, expected);
                    errors++;
                end
            end else if (addr.ram.select == cpu_bus_pkg::SELECT_RAM) begin
                for (int lane = 0; lane < 4; lane++) begin
                    if (e.wstrb[lane]) begin
                        model_ram[addr.ram.word_index][lane*8 +: 8] = write_data[lane*8 +: 8];
                    end
                end
            end
            checks++;
            if (cpu_irq !== e.exp_irq) begin
                $display("FAIL cpu_irq at %h: got %h, expected %h",
                         e.address, cpu_irq, e.exp_irq);
                errors++;
            end
        end
        // valid low for one cycle between accesses
        cpu_req.valid <= 1'b0;
        @(negedge clk_1x);
    endtask

    initial begin
        rst = 1'b1;
        cpu_req = '0;
        cpu_eoi = '0;
        irq_lines = '0;
        build_table();
        cycle_limit = 30 * stimulus.size() + RESET_CYCLES;
        repeat (RESET_CYCLES) @(negedge clk_1x);
        rst <= 1'b0;
        @(negedge clk_1x);
        foreach (stimulus[i]) begin
            case (stimulus[i].kind)
                SET_LINES: begin
                    irq_lines <= stimulus[i].data[cpu_bus_pkg::IRQ_LINES-1:0];
                    @(negedge clk_1x);
                end
                PULSE_EOI: begin
                    cpu_eoi <= stimulus[i].data;
                    @(negedge clk_1x);
                    cpu_eoi <= '0;
                    @(negedge clk_1x);
                end
                default: do_access(stimulus[i]);
            endcase
        end
        repeat (4) @(negedge clk_1x);
        checks++;
        if (ready_pulses != accesses) begin
            $display("saw %0d ready pulses for %0d accesses", ready_pulses, accesses);
            errors++;
        end
        assert_failures =
            peripheral_subsystem_inst.cpu_peripheral_sync_inst.sync_assertions_inst.failures;
        $display("checks %0d, errors %0d, assertion failures %0d", checks, errors, assert_failures);
        if (errors == 0 && assert_failures == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
verilog/cpu_bus_pkg.sv
verilog/cpu_peripheral_sync.sv
verilog/peripheral_bus_decoder.sv
verilog/scratch_ram.sv
verilog/irq_controller.sv
verilog/peripheral_subsystem.sv
test/peripheral_subsystem_assertions.sv
test/peripheral_subsystem_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the peripheral subsystem testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module peripheral_subsystem_tb -Mdir obj_dir -o sim -f verilog.f

./obj_dir/sim +verilator+error+limit+100 | tee sim.log

if grep -qx "Simulation passed" sim.log; then
    exit 0
fi
exit 1
